//--- list.f
+incdir+src
src/psgBusPkg.sv
src/psgVoicePkg.sv
src/psgBusArb.sv
src/psgWaveVoice.sv
src/psgBusMaster.sv
src/psgMixer.sv
src/psgWaveTop.sv
sim/psgSysMem.sv
sim/psgWaveTb.sv

//--- run.sh
#!/bin/bash
# build the wave table testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f list.f --top-module psgWaveTb -o psgWaveSim
./obj_dir/psgWaveSim | tee sim.log

if grep -q "^Test OK$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- sim/psgSysMem.sv
module psgSysMem (
	input logic clk,
	input logic rst,
	input logic hold,
	input psgBusPkg::sysBusT bus,
	output logic ack,
	output logic [15:0] data
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] SEED = 16'd57294;

	logic [15:0] words [0:65535];
	logic [15:0] lfsr;
	logic busy;
	logic nextAck;
	int waitLeft;

	// x^16 + x^14 + x^13 + x^11 + 1 in the right shifting Fibonacci form
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	// every word holds its own address inverted
	initial begin
		for (int i = 0; i < 65536; i++) begin
			words[i] = ~16'(i);
		end
		lfsr = SEED;
		busy = 1'b0;
		waitLeft = 0;
		nextAck = 1'b0;
		ack = 1'b0;
		data = 16'd0;
	end

	// ============================================================
	// cycle handling
	// ============================================================

	// the bus is looked at mid-cycle and the answer goes out just after
	// the following rising edge
	always begin
		logic [1:0] w;
		@(negedge clk);
		nextAck = 1'b0;
		if (rst || ack) begin
			// an ack that is still up gets taken at the coming edge
			busy = 1'b0;
		end else if (bus.cyc) begin
			if (!busy) begin
				// two fresh LFSR bits give 0 to 3 wait cycles
				for (int b = 0; b < 2; b++) begin
					w[b] = lfsr[0];
					lfsr = lfsrStep(lfsr);
				end
				busy = 1'b1;
				waitLeft = int'(w);
			end
			// hold freezes the countdown, which lets a test stretch a cycle
			if (!hold) begin
				if (waitLeft == 0) begin
					nextAck = 1'b1;
				end else begin
					waitLeft--;
				end
			end
		end
		@(posedge clk);
		#1;
		ack = nextAck;
		if (nextAck) begin
			data = words[bus.adr];
		end
	end

endmodule

//--- sim/psgWaveTb.sv
module psgWaveTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 10;

	// the watchdog is set from the sum of these per test cycle budgets
	localparam int RESET_LEN = 40;
	localparam int SINGLE_LEN = 400;
	localparam int BP_LEN = 200;
	localparam int PRIO_LEN = 200;
	localparam int MIX_LEN = 40;
	localparam int GATE_LEN = 300;
	localparam int WATCHDOG_LEN = RESET_LEN + SINGLE_LEN + BP_LEN + PRIO_LEN
		+ MIX_LEN + GATE_LEN + 300;

	// the lone voice of the address sequence test
	// eight ce per index keeps every fetch well ahead of the next step
	localparam logic [2:0] SV_VOICE = 3'd2;
	localparam logic [15:0] SV_FREQ = 16'h2000;
	localparam logic [15:0] SV_BASE = 16'h2a00;
	localparam logic [15:0] SV_LEN = 16'd5;
	localparam int SV_FETCHES = 8;

	logic clk;
	logic rst;
	logic ce;
	logic hold;
	psgVoicePkg::regWrT regWr;
	logic sysAck;
	logic [15:0] sysData;
	psgBusPkg::sysBusT sysBus;
	logic signed [15:0] audioOut;

	string curTest;
	int errCount;
	int errStart;
	int testsRun;
	int testsFailed;
	logic [15:0] doneAdr [$];
	logic wasWaiting;
	logic wasDone;
	logic [15:0] heldAdr;

	psgWaveTop uut (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.regWr(regWr),
		.sysAck(sysAck),
		.sysData(sysData),
		.sysBus(sysBus),
		.audioOut(audioOut)
	);

	psgSysMem uMem (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.bus(sysBus),
		.ack(sysAck),
		.data(sysData)
	);

	// ============================================================
	// clock, clock enable and watchdog
	// ============================================================

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	// one ce in every four cycles
	initial begin
		int phaseCnt;
		phaseCnt = 0;
		ce = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			ce = (phaseCnt == 3);
			phaseCnt = (phaseCnt + 1) % 4;
		end
	end

	initial begin
		#(WATCHDOG_LEN * CLK_PERIOD);
		$display("watchdog expired while test %s was still running", curTest);
		$display("Test FAILED");
		$finish;
	end

	// ============================================================
	// helpers
	// ============================================================

	task automatic reportMismatch(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		$display("ERROR %s: %s expected %h actual %h", curTest, what, exp, act);
		errCount++;
	endtask

	task automatic reportProblem(input string msg);
		$display("%s failed: %s", curTest, msg);
		errCount++;
	endtask

	task automatic startTest(input string name);
		curTest = name;
		errStart = errCount;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errCount == errStart) begin
			$display("%s: pass", curTest);
		end else begin
			testsFailed++;
			$display("%s: fail with %0d errors", curTest, errCount - errStart);
		end
	endtask

	// one host write held for a single cycle
	task automatic writeReg(input logic [2:0] voice, input psgVoicePkg::regOpT op,
		input logic [15:0] data);
		@(posedge clk);
		#1;
		regWr.stb = 1'b1;
		regWr.voice = voice;
		regWr.op = op;
		regWr.data = data;
		@(posedge clk);
		#1;
		regWr.stb = 1'b0;
	endtask

	task automatic setupVoice(input logic [2:0] v, input logic [15:0] freq,
		input logic [15:0] base, input logic [15:0] length, input logic [7:0] vol);
		writeReg(v, psgVoicePkg::opFreq, freq);
		writeReg(v, psgVoicePkg::opBase, base);
		writeReg(v, psgVoicePkg::opLength, length);
		writeReg(v, psgVoicePkg::opVolume, {8'd0, vol});
	endtask

	task automatic waitDone(input int count, input int limit);
		int n;
		n = 0;
		while (doneAdr.size() < count && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (doneAdr.size() >= count)
			else reportProblem($sformatf("only %0d of %0d bus cycles completed in time",
				doneAdr.size(), count));
	endtask

	task automatic waitCycOpen(input int limit);
		int n;
		n = 0;
		while (!sysBus.cyc && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (sysBus.cyc) else reportProblem("no bus cycle opened in time");
	endtask

	// distinct table per voice so the owner shows in the address
	function automatic logic [15:0] baseOf(input logic [2:0] v);
		return {1'b0, v, 4'h3, 8'h00};
	endfunction

	// the full mix of all eight voices clips at the negative limit
	// and falls back into range once voice 5 is gated off
	function automatic logic [7:0] volOf(input logic [2:0] v);
		return 8'd16 + 8'(v) * 8'd12;
	endfunction

	// sample is the inverted base word, scaled by volume, shifted by 8 and
	// clipped to 16 signed bits
	function automatic logic [15:0] expectedMix(input logic [7:0] gated);
		longint acc;
		longint term;
		logic signed [15:0] smp;
		acc = 0;
		for (int i = 0; i < 8; i++) begin
			if (gated[i]) begin
				smp = ~baseOf(3'(i));
				term = longint'(smp) * longint'(volOf(3'(i)));
				acc = acc + (term >>> 8);
			end
		end
		if (acc > 32767) begin
			acc = 32767;
		end else if (acc < -32768) begin
			acc = -32768;
		end
		return acc[15:0];
	endfunction

	// ============================================================
	// bus monitor
	// ============================================================

	// runs on the falling edge where every DUT output has settled
	always @(negedge clk) begin
		if (!rst) begin
			if (wasWaiting) begin
				assert (sysBus.cyc) else reportProblem("cycle dropped while sysAck was withheld");
				assert (sysBus.adr == heldAdr)
					else reportMismatch("held address", heldAdr, sysBus.adr);
			end
			if (wasDone) begin
				assert (!sysBus.cyc) else reportProblem("cycle stayed open after its sysAck");
			end
			if (sysAck) begin
				assert (sysBus.cyc) else reportProblem("sysAck came with no open cycle");
			end
			assert (uut.fetchRet.done == sysAck)
				else reportProblem("fetch return pulse does not line up with sysAck");
			if (sysBus.cyc && sysAck) begin
				doneAdr.push_back(sysBus.adr);
			end
		end
		wasWaiting = !rst && sysBus.cyc && !sysAck;
		wasDone = !rst && sysBus.cyc && sysAck;
		heldAdr = sysBus.adr;
	end

	// ============================================================
	// tests
	// ============================================================

	task automatic testReset();
		startTest("reset");
		repeat (30) begin
			@(negedge clk);
			assert (!sysBus.cyc) else reportProblem("bus cycle opened with no voice gated");
			assert (audioOut == 16'sd0) else reportMismatch("audioOut", 16'd0, audioOut);
		end
		finishTest();
	endtask

	task automatic testSingleVoice();
		logic [15:0] expAdr [$];
		logic [27:0] phase;
		logic [11:0] idx;
		startTest("singleVoice");
		// step the phase rule until enough index changes are known
		phase = 28'd0;
		idx = 12'd0;
		expAdr.push_back(SV_BASE);
		while (expAdr.size() < SV_FETCHES) begin
			phase = phase + {12'd0, SV_FREQ};
			if (phase[27:16] >= SV_LEN[11:0]) begin
				phase = {12'd0, phase[15:0]};
			end
			if (phase[27:16] != idx) begin
				idx = phase[27:16];
				expAdr.push_back(SV_BASE + {4'd0, idx});
			end
		end
		doneAdr.delete();
		setupVoice(SV_VOICE, SV_FREQ, SV_BASE, SV_LEN, 8'd0);
		writeReg(SV_VOICE, psgVoicePkg::opGate, 16'd1);
		waitDone(SV_FETCHES, SINGLE_LEN);
		for (int k = 0; k < SV_FETCHES && k < doneAdr.size(); k++) begin
			assert (doneAdr[k] == expAdr[k])
				else reportMismatch($sformatf("address %0d", k), expAdr[k], doneAdr[k]);
		end
		// quiet again before the shared bus tests start
		writeReg(SV_VOICE, psgVoicePkg::opGate, 16'd0);
		repeat (20) @(negedge clk);
		finishTest();
	endtask

	task automatic testBackPressure();
		startTest("backPressure");
		@(posedge clk);
		#1;
		hold = 1'b1;
		doneAdr.delete();
		setupVoice(3'd7, 16'd0, baseOf(3'd7), 16'd1, volOf(3'd7));
		writeReg(3'd7, psgVoicePkg::opGate, 16'd1);
		waitCycOpen(40);
		repeat (20) begin
			@(negedge clk);
			assert (sysBus.cyc) else reportProblem("cycle closed without sysAck");
			assert (sysBus.adr == baseOf(3'd7))
				else reportMismatch("stalled address", baseOf(3'd7), sysBus.adr);
		end
		assert (doneAdr.size() == 0) else reportProblem("a cycle completed with no sysAck");
		// the rest queue up behind the stalled voice
		for (int v = 6; v >= 0; v--) begin
			setupVoice(3'(v), 16'd0, baseOf(3'(v)), 16'd1, volOf(3'(v)));
			writeReg(3'(v), psgVoicePkg::opGate, 16'd1);
		end
		repeat (10) @(negedge clk);
		finishTest();
	endtask

	task automatic testPriority();
		logic [15:0] expAdr;
		startTest("priority");
		@(posedge clk);
		#1;
		hold = 1'b0;
		waitDone(8, PRIO_LEN);
		// voice 7 already owned the bus and the others follow in voice order
		for (int k = 0; k < 8 && k < doneAdr.size(); k++) begin
			expAdr = (k == 0) ? baseOf(3'd7) : baseOf(3'(k - 1));
			assert (doneAdr[k] == expAdr)
				else reportMismatch($sformatf("served address %0d", k), expAdr, doneAdr[k]);
		end
		repeat (20) @(negedge clk);
		assert (doneAdr.size() == 8)
			else reportProblem($sformatf("%0d cycles completed for 8 requests", doneAdr.size()));
		finishTest();
	endtask

	task automatic testMixer();
		startTest("mixer");
		// at least two ce pass so every returned sample has reached audioOut
		repeat (12) @(negedge clk);
		assert (audioOut == expectedMix(8'hff))
			else reportMismatch("audioOut", expectedMix(8'hff), audioOut);
		finishTest();
	endtask

	task automatic testGateOff();
		logic [15:0] gateBase;
		startTest("gateOff");
		gateBase = baseOf(3'd5);
		doneAdr.delete();
		// voice 5 walks a four word table until it is gated off
		writeReg(3'd5, psgVoicePkg::opLength, 16'd4);
		writeReg(3'd5, psgVoicePkg::opFreq, 16'h4000);
		waitDone(2, 100);
		writeReg(3'd5, psgVoicePkg::opGate, 16'd0);
		// a cycle that was already open may still finish
		repeat (30) @(negedge clk);
		doneAdr.delete();
		repeat (80) @(negedge clk);
		foreach (doneAdr[k]) begin
			assert (doneAdr[k] < gateBase || doneAdr[k] >= gateBase + 16'd4)
				else reportProblem($sformatf("gated off voice fetched %h", doneAdr[k]));
		end
		assert (audioOut == expectedMix(8'hdf))
			else reportMismatch("audioOut", expectedMix(8'hdf), audioOut);
		finishTest();
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		hold = 1'b0;
		regWr = '0;
		errCount = 0;
		errStart = 0;
		testsRun = 0;
		testsFailed = 0;
		curTest = "reset";
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		testReset();
		testSingleVoice();
		testBackPressure();
		testPriority();
		testMixer();
		testGateOff();

		$display("%0d tests run, %0d passed, %0d failed, %0d check errors",
			testsRun, testsRun - testsFailed, testsFailed, errCount);
		if (errCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- src/psgBusArb.sv
module psgBusArb (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ack,
	input logic [7:0] req,
	output psgBusPkg::busGrantT grant
);

	// ============================================================
	// fixed priority pick, voice 0 is the most urgent
	// ============================================================

	logic anyReq;
	logic [2:0] nextOwner;

	// scan from the top down so the lowest active request is left standing
	always_comb begin
		nextOwner = 3'd0;
		for (int i = 7; i >= 0; i--) begin
			if (req[i]) begin
				nextOwner = 3'(i);
			end
		end
	end

	assign anyReq = |req;

	// ============================================================
	// grant register
	// ============================================================

	// ownership only moves when ce lines up with a finished transfer
	// (or an idle bus), so a cycle in flight is never torn away from its owner
	always_ff @(posedge clk) begin
		if (rst) begin
			grant.sel <= 8'd0;
			grant.owner <= 3'd0;
		end else if (ce && ack && anyReq) begin
			grant.sel <= 8'd1 << nextOwner;
			grant.owner <= nextOwner;
		end
		// with nobody asking the last owner keeps the bus
	end

	// the bus master only opens a cycle for a selected owner, so right
	// after reset nothing moves until the first grant has been made
	//
	// a held owner that requests again is served straight away, even if a
	// lower voice is waiting, because the grant only changes on ce

endmodule

//--- src/psgBusMaster.sv
`include "psg_config.svh"

module psgBusMaster (
	input logic clk,
	input logic rst,
	input psgBusPkg::busGrantT grant,
	input psgBusPkg::busReqT busReq [`PSG_VOICES],
	input logic sysAck,
	input logic [15:0] sysData,
	output psgBusPkg::sysBusT sysBus,
	output logic xferDone,
	output psgBusPkg::fetchRetT fetchRet
);

	typedef enum logic {
		bmIdle,
		bmBusy
	} bmStateT;

	bmStateT state;
	logic start;
	logic [2:0] tag;
	logic [`PSG_ADR_W-1:0] adr;

	// ============================================================
	// transfer control
	// ============================================================

	// a cycle may open only for a voice that is both selected and asking
	assign start = (state == bmIdle) && grant.sel[grant.owner] && busReq[grant.owner].req;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bmIdle;
		end else begin
			case (state)
				bmIdle: begin
					if (start) begin
						state <= bmBusy;
					end
				end
				bmBusy: begin
					// the memory decides the latency, sysAck ends the cycle
					if (sysAck) begin
						state <= bmIdle;
					end
				end
				default: state <= bmIdle;
			endcase
		end
	end

	// address and owner are frozen for the whole cycle so a voice that
	// moves on does not disturb a transfer already on the bus
	always_ff @(posedge clk) begin
		if (start) begin
			tag <= grant.owner;
			adr <= busReq[grant.owner].adr;
		end
	end

	// ============================================================
	// outputs
	// ============================================================

	// the arbiter may move ownership when nothing is open or the open
	// cycle finishes this clock
	assign xferDone = (state == bmIdle) || sysAck;

	always_comb begin
		sysBus.cyc = (state == bmBusy);
		sysBus.adr = adr;
		// done coincides with sysAck and lasts one cycle by construction
		fetchRet.done = (state == bmBusy) && sysAck;
		fetchRet.owner = tag;
		fetchRet.data = sysData;
	end

endmodule

//--- src/psgBusPkg.sv
`include "psg_config.svh"

package psgBusPkg;

	// ============================================================
	// system bus side types
	// ============================================================

	// one voice asking for a word, held until its fetch comes back
	typedef struct packed {
		logic req;
		logic [`PSG_ADR_W-1:0] adr;
	} busReqT;

	// the arbiter's pick, select bits are one-hot once anyone was granted
	typedef struct packed {
		logic [7:0] sel;
		logic [2:0] owner;
	} busGrantT;

	// data going back to the voices, tagged with the voice it belongs to
	// done is a single-cycle pulse
	typedef struct packed {
		logic done;
		logic [2:0] owner;
		logic [15:0] data;
	} fetchRetT;

	// the outgoing system cycle, adr is only meaningful while cyc is high
	typedef struct packed {
		logic cyc;
		logic [`PSG_ADR_W-1:0] adr;
	} sysBusT;

endpackage

//--- src/psgMixer.sv
`include "psg_config.svh"

module psgMixer (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgVoicePkg::voiceOutT voices [`PSG_VOICES],
	output logic signed [15:0] audioOut
);

	// 16-bit sample times 9-bit signed volume fits in 25 bits, and eight
	// shifted terms never come close to overflowing that
	localparam int SUM_W = 25;

	logic signed [SUM_W-1:0] sum;
	logic signed [15:0] sat;

	// ============================================================
	// scale and sum
	// ============================================================

	always_comb begin
		logic signed [SUM_W-1:0] prod;
		sum = '0;
		for (int i = 0; i < `PSG_VOICES; i++) begin
			// volume is unsigned, so it gets a zero sign bit before the multiply
			prod = voices[i].sample * $signed({1'b0, voices[i].volume});
			if (voices[i].gate) begin
				sum = sum + (prod >>> `PSG_MIX_SHIFT);
			end
		end
	end

	// clip to the signed 16-bit range instead of wrapping
	always_comb begin
		if (sum > 25'sd32767) begin
			sat = 16'sh7fff;
		end else if (sum < -25'sd32768) begin
			sat = 16'sh8000;
		end else begin
			sat = sum[15:0];
		end
	end

	// ============================================================
	// output register
	// ============================================================

	// one new audio sample per ce
	always_ff @(posedge clk) begin
		if (rst) begin
			audioOut <= 16'sd0;
		end else if (ce) begin
			audioOut <= sat;
		end
	end

endmodule

//--- src/psgVoicePkg.sv
package psgVoicePkg;

	// ============================================================
	// voice side types
	// ============================================================

	// which voice register a host write lands in
	typedef enum logic [2:0] {
		opFreq,
		opBase,
		opLength,
		opVolume,
		opGate
	} regOpT;

	// one host register write, acted on only by the voice it names
	typedef struct packed {
		logic stb;
		logic [2:0] voice;
		regOpT op;
		logic [15:0] data;
	} regWrT;

	// vsIdle while gated off
	// vsRun while stepping with no word outstanding
	// vsFetch from raising the request until the word returns
	typedef enum logic [1:0] {
		vsIdle,
		vsRun,
		vsFetch
	} voiceStateT;

	// what each voice hands the mixer
	typedef struct packed {
		logic gate;
		logic signed [15:0] sample;
		logic [7:0] volume;
	} voiceOutT;

endpackage

//--- src/psgWaveTop.sv
`include "psg_config.svh"

module psgWaveTop (
	input logic clk,
	input logic rst,
	input logic ce,
	input psgVoicePkg::regWrT regWr,
	input logic sysAck,
	input logic [15:0] sysData,
	output psgBusPkg::sysBusT sysBus,
	output logic signed [15:0] audioOut
);

	psgBusPkg::busReqT busReq [`PSG_VOICES];
	psgVoicePkg::voiceOutT voiceOut [`PSG_VOICES];
	psgBusPkg::busGrantT grant;
	psgBusPkg::fetchRetT fetchRet;
	logic [`PSG_VOICES-1:0] reqBits;
	logic xferDone;

	// ============================================================
	// voices
	// ============================================================

	// every voice sees the host write and the return data, the voice
	// number sorts out who acts on them
	for (genvar i = 0; i < `PSG_VOICES; i++) begin : gVoice
		psgWaveVoice uVoice (
			.clk(clk),
			.rst(rst),
			.ce(ce),
			.voiceId(3'(i)),
			.regWr(regWr),
			.fetchRet(fetchRet),
			.busReq(busReq[i]),
			.voiceOut(voiceOut[i])
		);

		assign reqBits[i] = busReq[i].req;
	end

	// ============================================================
	// bus side
	// ============================================================

	psgBusArb uArb (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ack(xferDone),
		.req(reqBits),
		.grant(grant)
	);

	psgBusMaster uMaster (
		.clk(clk),
		.rst(rst),
		.grant(grant),
		.busReq(busReq),
		.sysAck(sysAck),
		.sysData(sysData),
		.sysBus(sysBus),
		.xferDone(xferDone),
		.fetchRet(fetchRet)
	);

	// ============================================================
	// audio side
	// ============================================================

	psgMixer uMixer (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.voices(voiceOut),
		.audioOut(audioOut)
	);

endmodule

//--- src/psgWaveVoice.sv
`include "psg_config.svh"

module psgWaveVoice (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [2:0] voiceId,
	input psgVoicePkg::regWrT regWr,
	input psgBusPkg::fetchRetT fetchRet,
	output psgBusPkg::busReqT busReq,
	output psgVoicePkg::voiceOutT voiceOut
);

	localparam int FRAC = `PSG_PHASE_FRAC;
	localparam int IDX_W = `PSG_INDEX_W;
	localparam int PH_W = IDX_W + FRAC;
	localparam int ADR_W = `PSG_ADR_W;

	logic [15:0] freq;
	logic [ADR_W-1:0] base;
	logic [IDX_W-1:0] length;
	logic [7:0] volume;
	logic gate;
	logic signed [15:0] sample;

	logic [PH_W-1:0] phase;
	logic [PH_W-1:0] phaseSum;
	logic [PH_W-1:0] phaseNext;
	logic [IDX_W-1:0] index;

	psgVoicePkg::voiceStateT state;
	logic reqOut;
	logic pend;

	logic wrMe;
	logic gateOn;
	logic gateOff;
	logic idxChg;
	logic myRet;

	// ============================================================
	// register file
	// ============================================================

	assign wrMe = regWr.stb && (regWr.voice == voiceId);
	assign gateOn = wrMe && (regWr.op == psgVoicePkg::opGate) && regWr.data[0] && !gate;
	assign gateOff = wrMe && (regWr.op == psgVoicePkg::opGate) && !regWr.data[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= 16'd0;
			base <= '0;
			length <= '0;
			volume <= 8'd0;
			gate <= 1'b0;
		end else if (wrMe) begin
			case (regWr.op)
				psgVoicePkg::opFreq: freq <= regWr.data;
				psgVoicePkg::opBase: base <= regWr.data[ADR_W-1:0];
				psgVoicePkg::opLength: length <= regWr.data[IDX_W-1:0];
				psgVoicePkg::opVolume: volume <= regWr.data[7:0];
				psgVoicePkg::opGate: gate <= regWr.data[0];
				default: ;
			endcase
		end
	end

	// ============================================================
	// phase accumulator
	// ============================================================

	assign index = phase[PH_W-1:FRAC];
	assign phaseSum = phase + PH_W'(freq);

	// reaching the length wraps the index to zero, the fraction carries on
	always_comb begin
		if (phaseSum[PH_W-1:FRAC] >= length) begin
			phaseNext = {{IDX_W{1'b0}}, phaseSum[FRAC-1:0]};
		end else begin
			phaseNext = phaseSum;
		end
	end

	// high on the edge where the stepped index differs from the current one
	assign idxChg = ce && gate && (phaseNext[PH_W-1:FRAC] != index);

	always_ff @(posedge clk) begin
		if (rst || gateOn) begin
			phase <= '0;
		end else if (ce && gate) begin
			phase <= phaseNext;
		end
	end

	// ============================================================
	// fetch request
	// ============================================================

	assign myRet = fetchRet.done && (fetchRet.owner == voiceId);

	// pend remembers that a new index needs a word, the request follows
	// one edge later
	always_ff @(posedge clk) begin
		if (rst || gateOff) begin
			state <= psgVoicePkg::vsIdle;
			reqOut <= 1'b0;
			pend <= 1'b0;
		end else if (gateOn) begin
			state <= psgVoicePkg::vsRun;
			pend <= 1'b1;
		end else begin
			case (state)
				psgVoicePkg::vsRun: begin
					if (pend) begin
						reqOut <= 1'b1;
						state <= psgVoicePkg::vsFetch;
						pend <= 1'b0;
					end else begin
						pend <= idxChg;
					end
				end
				psgVoicePkg::vsFetch: begin
					// while waiting the address tracks the index, so a newer
					// index rides on the same request
					if (myRet) begin
						reqOut <= 1'b0;
						state <= psgVoicePkg::vsRun;
						pend <= idxChg;
					end
				end
				default: ;
			endcase
		end
	end

	// a fresh gate starts from silence until the first word lands
	always_ff @(posedge clk) begin
		if (gateOn) begin
			sample <= 16'sd0;
		end else if (myRet && state == psgVoicePkg::vsFetch) begin
			sample <= fetchRet.data;
		end
	end

	always_comb begin
		busReq.req = reqOut;
		busReq.adr = base + ADR_W'(index);
		voiceOut.gate = gate;
		voiceOut.sample = sample;
		voiceOut.volume = volume;
	end

endmodule

//--- src/psg_config.svh
`ifndef PSG_CONFIG_SVH
`define PSG_CONFIG_SVH

// ============================================================
// build-time sizing of the wave table side of the PSG
// ============================================================

// number of wave table voices sharing the one system bus port
// the arbiter is wired for exactly eight of them
`define PSG_VOICES 8

// width of a system word address
`define PSG_ADR_W 16

// fractional bits kept below the sample index in each phase accumulator
// a frequency word of 1 << PSG_PHASE_FRAC steps one sample per ce
`define PSG_PHASE_FRAC 16

// integer sample index width, which also bounds the table length
`define PSG_INDEX_W 12

// right shift applied after sample times volume
// an 8-bit volume of 255 then gives just under unity gain
`define PSG_MIX_SHIFT 8

`endif
